// File: bench/dma_target_checker.sv
//////////////////////////////////////////////////
// DMA target protocol assertions
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dma_target_checker (
  input logic                      clk,
  input logic                      rst,
  input dma_target_pkg::dma_flit_t out_flit_i,
  input logic                      out_valid_i,
  input logic                      out_ready_i,
  input logic                      in_ready_i,
  input logic                      resp_idle_i,
  input logic                      mem_en_i,
  input logic                      mem_we_i,
  input logic                      rd_pend_i,
  input logic                      fifo_full_i
);

  int fail_count = 0;

  // Stalled output flit stays put
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
    out_valid_i && !out_ready_i |=> out_valid_i && $stable(out_flit_i))
  else begin
    fail_count++;
    $error("out_flit_o dropped or changed while stalled");
  end

  a_busy_stall: assert property (@(posedge clk) disable iff (rst)
    !resp_idle_i |-> !in_ready_i)
  else begin
    fail_count++;
    $error("in_ready_o high during a response");
  end

  a_we_vs_read: assert property (@(posedge clk) disable iff (rst)
    !(mem_we_i && rd_pend_i))
  else begin
    fail_count++;
    $error("memory write during a pending read");
  end

  // Pending read pushes next cycle
  a_push_full: assert property (@(posedge clk) disable iff (rst)
    !(rd_pend_i && fifo_full_i))
  else begin
    fail_count++;
    $error("read FIFO pushed while full");
  end

  a_reset_quiet: assert property (@(posedge clk)
    rst && $past(rst) |-> !out_valid_i && !mem_en_i)
  else begin
    fail_count++;
    $error("out_valid_o or mem_en_o high in reset");
  end

endmodule

bind dma_target dma_target_checker u_checker (
  .clk         (clk),
  .rst         (rst),
  .out_flit_i  (out_flit_o),
  .out_valid_i (out_valid_o),
  .out_ready_i (out_ready_i),
  .in_ready_i  (in_ready_o),
  .resp_idle_i (resp_idle),
  .mem_en_i    (mem_en_o),
  .mem_we_i    (mem_we_o),
  .rd_pend_i   (u_mem_access.rd_pend_q),
  .fifo_full_i (u_mem_access.u_fifo.pos_q[3])
);

`default_nettype wire

// File: bench/dma_target_monitor.sv
//////////////////////////////////////////////////
// NoC output monitor
// Compares accepted flits with the expected stream
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dma_target_config.svh"

module dma_target_monitor (
  input  logic                      clk,
  input  logic                      rst,
  input  dma_target_pkg::dma_flit_t out_flit_i,
  input  logic                      out_valid_i,
  input  logic                      out_ready_i,
  output int                        mismatches_o,
  output int                        errors_o,
  output int                        pending_o
);

  // Expected flits in NoC order
  dma_target_pkg::dma_flit_t exp_q[$];
  dma_target_pkg::dma_flit_t exp_flit;
  int                        n_pushed   = 0;
  int                        n_popped   = 0;
  int                        n_seen     = 0;
  int                        mismatches = 0;
  int                        errors     = 0;

  assign mismatches_o = mismatches;
  assign errors_o     = errors;
  assign pending_o    = n_pushed - n_popped;

  task automatic push_expected(input dma_target_pkg::dma_flit_t f);
    exp_q.push_back(f);
    n_pushed++;
  endtask

  // A flit counts once both valid and ready are high at the edge
  always @(posedge clk) begin
    if (!rst && out_valid_i && out_ready_i) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("[%0t] out_flit_o sent %h while no flit was expected",
                 $time, out_flit_i);
      end else begin
        exp_flit = exp_q.pop_front();
        n_popped++;
        if (out_flit_i !== exp_flit) begin
          mismatches++;
          $display("MISMATCH t=%0t out_flit_o[%0d] expected %h got %h",
                   $time, n_seen, exp_flit, out_flit_i);
        end
      end
      n_seen++;
    end
  end

endmodule

`default_nettype wire

// File: bench/tb_dma_target.sv
//////////////////////////////////////////////////
// DMA target testbench
// Random L2R/R2L traffic, memory model, final report
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dma_target_config.svh"

module tb_dma_target;

  localparam int NUM_REQ        = 40;
  // Requests times worst-case flits times stall cycles per flit
  localparam int TIMEOUT_CYCLES = NUM_REQ * 60 * 8;

  logic                       clk = 1'b0;
  logic                       rst;
  dma_target_pkg::dma_flit_t  in_flit_i;
  logic                       in_valid_i;
  logic                       in_ready_o;
  dma_target_pkg::dma_flit_t  out_flit_o;
  logic                       out_valid_o;
  logic                       out_ready_i;
  logic                       mem_en_o;
  logic                       mem_we_o;
  logic [`DMA_ADDR_WIDTH-1:0] mem_addr_o;
  logic [`DMA_DATA_WIDTH-1:0] mem_wdata_o;
  logic [`DMA_DATA_WIDTH-1:0] mem_rdata_i;

  // Memory behind the DUT port, and what it should hold
  logic [`DMA_DATA_WIDTH-1:0] mem     [256];
  logic [`DMA_DATA_WIDTH-1:0] ref_mem [256];
  logic                       rd_en;
  logic [7:0]                 rd_idx;

  logic [31:0] lfsr_q;
  int          cycle_count   = 0;
  int          tb_mismatches = 0;
  int          tb_errors     = 0;
  int          mon_mismatches;
  int          mon_errors;
  int          pending;

  always #50 clk = ~clk;

  dma_target dut (.*);

  dma_target_monitor mon (
    .clk          (clk),
    .rst          (rst),
    .out_flit_i   (out_flit_o),
    .out_valid_i  (out_valid_o),
    .out_ready_i  (out_ready_i),
    .mismatches_o (mon_mismatches),
    .errors_o     (mon_errors),
    .pending_o    (pending)
  );

  //////////////////////////////////////////////////
  // Memory model, one-cycle read latency
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    rd_en  = mem_en_o && !mem_we_o;
    rd_idx = mem_addr_o[9:2];
    if (mem_en_o && mem_we_o) begin
      mem[mem_addr_o[9:2]] = mem_wdata_o;
    end
    // Read data lands just after the edge, like the other inputs
    #1;
    if (rd_en) begin
      mem_rdata_i = mem[rd_idx];
    end
  end

  function automatic int error_total();
    return tb_mismatches + mon_mismatches + tb_errors + mon_errors + dut.u_checker.fail_count;
  endfunction

  task automatic print_counts();
    $display("errors: mismatch=%0d protocol=%0d assertion=%0d",
             tb_mismatches + mon_mismatches, tb_errors + mon_errors,
             dut.u_checker.fail_count);
  endtask

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("[%0t] timeout, run did not end within %0d cycles", $time, TIMEOUT_CYCLES);
      print_counts();
      $display("=== FAIL ===");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  // Galois LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_step(lfsr_q);
    end
    return v;
  endfunction

  function automatic dma_target_pkg::dma_flit_t hdr_flit(
    input dma_target_pkg::flit_type_e ftype,
    input logic [4:0]                 dest,
    input logic [4:0]                 src,
    input dma_target_pkg::pkt_type_e  ptype,
    input logic [3:0]                 id,
    input logic                       last,
    input int                         size
  );
    dma_target_pkg::dma_flit_t f;
    f                   = '0;
    f.ftype             = ftype;
    f.body.hdr.dest     = dest;
    f.body.hdr.cls      = `DMA_PKT_CLASS;
    f.body.hdr.src      = src;
    f.body.hdr.pkt_type = ptype;
    f.body.hdr.pkt_id   = id;
    f.body.hdr.last     = last;
    f.body.hdr.size     = `DMA_SIZE_WIDTH'(size);
    return f;
  endfunction

  function automatic dma_target_pkg::dma_flit_t word_flit(
    input dma_target_pkg::flit_type_e ftype,
    input logic [31:0]                w
  );
    dma_target_pkg::dma_flit_t f;
    f           = '0;
    f.ftype     = ftype;
    f.body.word = w;
    return f;
  endfunction

  // Advance to just after the next edge, new random out_ready_i
  task automatic next_cycle();
    @(posedge clk);
    #1;
    out_ready_i = (rand_bits(2) != 32'd0);
  endtask

  // Random gap, then hold the flit until the DUT takes it
  task automatic send_flit(input dma_target_pkg::dma_flit_t f);
    logic taken;
    taken = 1'b0;
    while (rand_bits(2) == 32'd0) begin
      in_valid_i = 1'b0;
      next_cycle();
    end
    in_valid_i = 1'b1;
    in_flit_i  = f;
    while (!taken) begin
      taken = in_ready_o;
      next_cycle();
    end
    in_valid_i = 1'b0;
  endtask

  // Expected responses are queued before the request goes out
  task automatic run_request();
    logic                      is_r2l;
    int                        n;
    int                        base;
    int                        sent;
    int                        pw;
    logic [3:0]                id;
    logic [4:0]                src;
    logic [31:0]               raddr;
    logic [31:0]               data;
    dma_target_pkg::flit_type_e ft;
    is_r2l = 1'(rand_bits(1));
    n      = 1 + int'(rand_bits(6) % 32'd40);
    base   = int'(rand_bits(6));
    id     = 4'(rand_bits(4));
    src    = 5'(rand_bits(5));
    if (!is_r2l) begin
      mon.push_expected(hdr_flit(dma_target_pkg::FLIT_SINGLE, src, `DMA_TILE_ID,
                                 dma_target_pkg::PKT_L2R_RESP, id, 1'b0, 0));
      send_flit(hdr_flit(dma_target_pkg::FLIT_HEADER, `DMA_TILE_ID, src,
                         dma_target_pkg::PKT_L2R_REQ, id, 1'b0, n));
      send_flit(word_flit(dma_target_pkg::FLIT_PAYLOAD, 32'(base * 4)));
      for (int k = 0; k < n; k++) begin
        data                  = rand_bits(32);
        ref_mem[8'(base + k)] = data;
        ft = (k == n - 1) ? dma_target_pkg::FLIT_LAST : dma_target_pkg::FLIT_PAYLOAD;
        send_flit(word_flit(ft, data));
      end
    end else begin
      raddr = rand_bits(30) << 2;
      sent  = 0;
      // Split into packets of at most MAX_PAYLOAD words
      while (sent < n) begin
        pw = (n - sent > `DMA_MAX_PAYLOAD) ? `DMA_MAX_PAYLOAD : n - sent;
        mon.push_expected(hdr_flit(dma_target_pkg::FLIT_HEADER, src, `DMA_TILE_ID,
                                   dma_target_pkg::PKT_R2L_RESP, id, sent + pw == n, pw));
        mon.push_expected(word_flit(dma_target_pkg::FLIT_PAYLOAD, raddr + 32'(sent * 4)));
        for (int k = 0; k < pw; k++) begin
          ft = (k == pw - 1) ? dma_target_pkg::FLIT_LAST : dma_target_pkg::FLIT_PAYLOAD;
          mon.push_expected(word_flit(ft, ref_mem[8'(base + sent + k)]));
        end
        sent += pw;
      end
      send_flit(hdr_flit(dma_target_pkg::FLIT_HEADER, `DMA_TILE_ID, src,
                         dma_target_pkg::PKT_R2L_REQ, id, 1'b0, n));
      send_flit(word_flit(dma_target_pkg::FLIT_PAYLOAD, 32'(base * 4)));
      send_flit(word_flit(dma_target_pkg::FLIT_LAST, raddr));
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    rst         = 1'b1;
    in_valid_i  = 1'b0;
    in_flit_i   = '0;
    out_ready_i = 1'b0;
    mem_rdata_i = '0;
    lfsr_q      = 32'h63d2b0bb;
    for (int i = 0; i < 256; i++) begin
      mem[8'(i)]     = 32'h5a3c_0000 ^ (32'(i) * 32'h0001_0101);
      ref_mem[8'(i)] = mem[8'(i)];
    end
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    if (!in_ready_o || out_valid_o || mem_en_o) begin
      tb_errors++;
      $display("[%0t] DUT ports are not idle after reset", $time);
    end
    repeat (NUM_REQ) run_request();
    // Drain the last responses, then watch for stray flits
    while (pending != 0 || !in_ready_o) begin
      next_cycle();
    end
    repeat (20) next_cycle();
    for (int i = 0; i < 256; i++) begin
      if (mem[8'(i)] !== ref_mem[8'(i)]) begin
        tb_mismatches++;
        $display("MISMATCH t=%0t mem[%0d] expected %h got %h",
                 $time, i, ref_mem[8'(i)], mem[8'(i)]);
      end
    end
    print_counts();
    if (error_total() == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
hw/dma_target_pkg.sv
hw/dma_req_decoder.sv
hw/dma_read_fifo.sv
hw/dma_mem_access.sv
hw/dma_resp_gen.sv
hw/dma_target.sv
bench/dma_target_checker.sv
bench/dma_target_monitor.sv
bench/tb_dma_target.sv

// File: hw/dma_mem_access.sv
//////////////////////////////////////////////////
// Local memory port driver
// L2R writes, paced R2L reads into the read FIFO
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dma_target_config.svh"

module dma_mem_access (
  input  logic                       clk,
  input  logic                       rst,
  input  dma_target_pkg::mem_wr_t    wr_i,
  input  dma_target_pkg::dma_req_t   req_i,
  input  logic                       r2l_start_i,
  output logic                       mem_en_o,
  output logic                       mem_we_o,
  output logic [`DMA_ADDR_WIDTH-1:0] mem_addr_o,
  output logic [`DMA_DATA_WIDTH-1:0] mem_wdata_o,
  input  logic [`DMA_DATA_WIDTH-1:0] mem_rdata_i,
  input  logic                       rd_pop_i,
  output logic                       rd_valid_o,
  output logic [`DMA_DATA_WIDTH-1:0] rd_data_o
);

  logic [`DMA_ADDR_WIDTH-1:0] rd_addr_q;
  logic [`DMA_SIZE_WIDTH-1:0] rd_left_q;
  // Read issued last cycle, data on mem_rdata_i now
  logic                       rd_pend_q;
  logic                       rd_issue;
  logic [1:0]                 fifo_level;
  logic [2:0]                 fifo_used;

  // Count in-flight read as occupied so a push never hits a full FIFO
  assign fifo_used = {1'b0, fifo_level} + {2'b00, rd_pend_q};
  // Writes win the port, they never overlap reads anyway
  assign rd_issue  = (rd_left_q != '0) && (fifo_used < 3'd3) && !wr_i.en;

  // Memory port
  assign mem_en_o    = wr_i.en | rd_issue;
  assign mem_we_o    = wr_i.en;
  assign mem_addr_o  = wr_i.en ? wr_i.addr : rd_addr_q;
  assign mem_wdata_o = wr_i.data;

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_left_q <= '0;
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= rd_issue;
      if (r2l_start_i) begin
        rd_left_q <= req_i.words;
      end else if (rd_issue) begin
        rd_left_q <= rd_left_q - `DMA_SIZE_WIDTH'(1);
      end
    end
  end

  // Word addresses step by four bytes
  always_ff @(posedge clk) begin
    if (r2l_start_i) begin
      rd_addr_q <= req_i.laddr;
    end else if (rd_issue) begin
      rd_addr_q <= rd_addr_q + `DMA_ADDR_WIDTH'(4);
    end
  end

  dma_read_fifo u_fifo (
    .clk         (clk),
    .rst         (rst),
    .push_i      (rd_pend_q),
    .push_data_i (mem_rdata_i),
    .pop_i       (rd_pop_i),
    .pop_data_o  (rd_data_o),
    .valid_o     (rd_valid_o),
    .level_o     (fifo_level)
  );

endmodule

`default_nettype wire

// File: hw/dma_read_fifo.sv
//////////////////////////////////////////////////
// Three-entry shift FIFO for R2L read data
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dma_target_config.svh"

module dma_read_fifo (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       push_i,
  input  logic [`DMA_DATA_WIDTH-1:0] push_data_i,
  input  logic                       pop_i,
  output logic [`DMA_DATA_WIDTH-1:0] pop_data_o,
  output logic                       valid_o,
  output logic [1:0]                 level_o
);

  logic [`DMA_DATA_WIDTH-1:0] entry_q [3];
  // One-hot write position, bit 0 empty, bit 3 full
  logic [3:0]                 pos_q;

  // Outputs come from registers only
  assign valid_o    = ~pos_q[0];
  assign pop_data_o = entry_q[0];
  assign level_o    = {pos_q[3] | pos_q[2], pos_q[3] | pos_q[1]};

  always_ff @(posedge clk) begin
    if (rst) begin
      pos_q <= 4'b0001;
    end else if (push_i && !pop_i) begin
      pos_q <= pos_q << 1;
    end else if (pop_i && !push_i) begin
      pos_q <= pos_q >> 1;
    end
  end

  // Head is always entry 0, pop shifts everything down by one
  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      if (pop_i) begin
        // Push into the slot that the shift frees up
        if (push_i && pos_q[i+1]) begin
          entry_q[i] <= push_data_i;
        end else begin
          entry_q[i] <= entry_q[(i < 2) ? i + 1 : i];
        end
      end else if (push_i && pos_q[i]) begin
        entry_q[i] <= push_data_i;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/dma_req_decoder.sv
//////////////////////////////////////////////////
// DMA request decoder
// Parses request flits, issues L2R memory writes
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dma_target_config.svh"

module dma_req_decoder (
  input  logic                      clk,
  input  logic                      rst,
  input  dma_target_pkg::dma_flit_t in_flit_i,
  input  logic                      in_valid_i,
  output logic                      in_ready_o,
  input  logic                      resp_idle_i,
  output dma_target_pkg::mem_wr_t   wr_o,
  output dma_target_pkg::dma_req_t  req_o,
  output logic                      l2r_done_o,
  output logic                      r2l_start_o
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_L2R_ADDR,
    S_L2R_DATA,
    S_R2L_LADDR,
    S_R2L_RADDR,
    S_WAIT
  } state_e;

  state_e                   state_q;
  state_e                   state_d;
  dma_target_pkg::dma_req_t req_q;
  logic                     in_fire;
  logic                     in_last;

  // Busy while a response is pending, input is stalled
  assign in_ready_o = (state_q != S_WAIT);
  assign in_fire    = in_valid_i & in_ready_o;
  assign in_last    = (in_flit_i.ftype == dma_target_pkg::FLIT_LAST);
  assign req_o      = req_q;

  //////////////////////////////////////////////////
  // FSM
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      S_IDLE: begin
        if (in_fire) begin
          // Header view of the flit body
          case (in_flit_i.body.hdr.pkt_type)
            dma_target_pkg::PKT_L2R_REQ: state_d = S_L2R_ADDR;
            dma_target_pkg::PKT_R2L_REQ: state_d = S_R2L_LADDR;
            // Anything else is dropped
            default:                     state_d = S_IDLE;
          endcase
        end
      end
      S_L2R_ADDR:  if (in_fire) state_d = S_L2R_DATA;
      S_L2R_DATA:  if (in_fire && in_last) state_d = S_WAIT;
      S_R2L_LADDR: if (in_fire) state_d = S_R2L_RADDR;
      S_R2L_RADDR: if (in_fire) state_d = S_WAIT;
      // Response side is still idle during the start pulse itself
      S_WAIT:      if (resp_idle_i && !l2r_done_o && !r2l_start_o) state_d = S_IDLE;
      default:     state_d = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= S_IDLE;
      l2r_done_o  <= 1'b0;
      r2l_start_o <= 1'b0;
    end else begin
      state_q     <= state_d;
      l2r_done_o  <= in_fire && in_last && (state_q == S_L2R_DATA);
      r2l_start_o <= in_fire && (state_q == S_R2L_RADDR);
    end
  end

  //////////////////////////////////////////////////
  // Request capture
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (in_fire) begin
      case (state_q)
        S_IDLE: begin
          req_q.src   <= in_flit_i.body.hdr.src;
          req_q.id    <= in_flit_i.body.hdr.pkt_id;
          req_q.words <= in_flit_i.body.hdr.size;
        end
        S_L2R_ADDR, S_R2L_LADDR: req_q.laddr <= in_flit_i.body.word;
        // Local address doubles as the L2R write pointer
        S_L2R_DATA:  req_q.laddr <= req_q.laddr + `DMA_ADDR_WIDTH'(4);
        S_R2L_RADDR: req_q.raddr <= in_flit_i.body.word;
        default: ;
      endcase
    end
  end

  // One write per accepted data flit, same cycle
  always_comb begin
    wr_o.en   = in_fire && (state_q == S_L2R_DATA);
    wr_o.addr = req_q.laddr;
    wr_o.data = in_flit_i.body.word;
  end

endmodule

`default_nettype wire

// File: hw/dma_resp_gen.sv
//////////////////////////////////////////////////
// DMA response generator
// L2R acks and packetized R2L read data on the NoC
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dma_target_config.svh"

module dma_resp_gen (
  input  logic                       clk,
  input  logic                       rst,
  input  dma_target_pkg::dma_req_t   req_i,
  input  logic                       l2r_done_i,
  input  logic                       r2l_start_i,
  input  logic                       rd_valid_i,
  input  logic [`DMA_DATA_WIDTH-1:0] rd_data_i,
  output logic                       rd_pop_o,
  output dma_target_pkg::dma_flit_t  out_flit_o,
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output logic                       resp_idle_o
);

  localparam logic [`DMA_SIZE_WIDTH-1:0] MAX_PAYLOAD = `DMA_SIZE_WIDTH'(`DMA_MAX_PAYLOAD);

  typedef enum logic [2:0] {
    S_IDLE,
    S_L2R_RESP,
    S_R2L_HDR,
    S_R2L_ADDR,
    S_R2L_DATA
  } state_e;

  state_e                   state_q;
  // Words sent in earlier packets of this request
  logic [`DMA_SIZE_WIDTH-1:0] sent_q;
  // Data flits in the current packet and index within it
  logic [`DMA_SIZE_WIDTH-1:0] pkt_size_q;
  logic [`DMA_SIZE_WIDTH-1:0] pkt_cnt_q;
  logic [`DMA_SIZE_WIDTH-1:0] words_left;
  logic [`DMA_SIZE_WIDTH-1:0] pkt_words;
  logic                       pkt_end;
  logic                       out_fire;
  dma_target_pkg::dma_hdr_t   resp_hdr;

  assign words_left  = req_i.words - sent_q;
  assign pkt_words   = (words_left > MAX_PAYLOAD) ? MAX_PAYLOAD : words_left;
  assign pkt_end     = (pkt_cnt_q == pkt_size_q - `DMA_SIZE_WIDTH'(1));
  assign out_fire    = out_valid_o & out_ready_i;
  assign rd_pop_o    = (state_q == S_R2L_DATA) & out_fire;
  assign resp_idle_o = (state_q == S_IDLE);

  //////////////////////////////////////////////////
  // Output flit
  //////////////////////////////////////////////////

  always_comb begin
    // Fields common to both response headers, back to the requester
    resp_hdr          = '0;
    resp_hdr.dest     = req_i.src;
    resp_hdr.cls      = `DMA_PKT_CLASS;
    resp_hdr.src      = `DMA_TILE_ID;
    resp_hdr.pkt_id   = req_i.id;
    out_flit_o        = '0;
    out_valid_o       = 1'b0;
    case (state_q)
      S_L2R_RESP: begin
        resp_hdr.pkt_type = dma_target_pkg::PKT_L2R_RESP;
        out_valid_o       = 1'b1;
        out_flit_o.ftype  = dma_target_pkg::FLIT_SINGLE;
        out_flit_o.body   = resp_hdr;
      end
      S_R2L_HDR: begin
        resp_hdr.pkt_type = dma_target_pkg::PKT_R2L_RESP;
        resp_hdr.last     = (words_left <= MAX_PAYLOAD);
        resp_hdr.size     = pkt_words;
        out_valid_o       = 1'b1;
        out_flit_o.ftype  = dma_target_pkg::FLIT_HEADER;
        out_flit_o.body   = resp_hdr;
      end
      S_R2L_ADDR: begin
        // Remote address advanced past the words already returned
        out_valid_o          = 1'b1;
        out_flit_o.ftype     = dma_target_pkg::FLIT_PAYLOAD;
        out_flit_o.body.word = req_i.raddr + (`DMA_ADDR_WIDTH'(sent_q) << 2);
      end
      S_R2L_DATA: begin
        out_valid_o          = rd_valid_i;
        out_flit_o.ftype     = pkt_end ? dma_target_pkg::FLIT_LAST
                                       : dma_target_pkg::FLIT_PAYLOAD;
        out_flit_o.body.word = rd_data_i;
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // FSM and counters
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= S_IDLE;
      sent_q     <= '0;
      pkt_size_q <= '0;
      pkt_cnt_q  <= '0;
    end else begin
      case (state_q)
        S_IDLE: begin
          sent_q <= '0;
          if (l2r_done_i) begin
            state_q <= S_L2R_RESP;
          end else if (r2l_start_i) begin
            state_q <= S_R2L_HDR;
          end
        end
        S_L2R_RESP: if (out_fire) state_q <= S_IDLE;
        S_R2L_HDR: begin
          if (out_fire) begin
            state_q    <= S_R2L_ADDR;
            pkt_size_q <= pkt_words;
            pkt_cnt_q  <= '0;
          end
        end
        S_R2L_ADDR: if (out_fire) state_q <= S_R2L_DATA;
        S_R2L_DATA: begin
          if (out_fire && pkt_end) begin
            sent_q  <= sent_q + pkt_size_q;
            // Request done once this packet covers all remaining words
            state_q <= (pkt_size_q == words_left) ? S_IDLE : S_R2L_HDR;
          end else if (out_fire) begin
            pkt_cnt_q <= pkt_cnt_q + `DMA_SIZE_WIDTH'(1);
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/dma_target.sv
//////////////////////////////////////////////////
// DMA target top level
// Request decoder, memory access, response generator
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "dma_target_config.svh"

module dma_target (
  input  logic                       clk,
  input  logic                       rst,
  // NoC input
  input  dma_target_pkg::dma_flit_t  in_flit_i,
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  // NoC output
  output dma_target_pkg::dma_flit_t  out_flit_o,
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  // Local memory
  output logic                       mem_en_o,
  output logic                       mem_we_o,
  output logic [`DMA_ADDR_WIDTH-1:0] mem_addr_o,
  output logic [`DMA_DATA_WIDTH-1:0] mem_wdata_o,
  input  logic [`DMA_DATA_WIDTH-1:0] mem_rdata_i
);

  dma_target_pkg::mem_wr_t    wr;
  dma_target_pkg::dma_req_t   req;
  logic                       l2r_done;
  logic                       r2l_start;
  logic                       resp_idle;
  // Read FIFO head towards the response side
  logic                       rd_valid;
  logic                       rd_pop;
  logic [`DMA_DATA_WIDTH-1:0] rd_data;

  dma_req_decoder u_decoder (
    .clk         (clk),
    .rst         (rst),
    .in_flit_i   (in_flit_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .resp_idle_i (resp_idle),
    .wr_o        (wr),
    .req_o       (req),
    .l2r_done_o  (l2r_done),
    .r2l_start_o (r2l_start)
  );

  dma_mem_access u_mem_access (
    .clk         (clk),
    .rst         (rst),
    .wr_i        (wr),
    .req_i       (req),
    .r2l_start_i (r2l_start),
    .mem_en_o    (mem_en_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_rdata_i (mem_rdata_i),
    .rd_pop_i    (rd_pop),
    .rd_valid_o  (rd_valid),
    .rd_data_o   (rd_data)
  );

  dma_resp_gen u_resp_gen (
    .clk         (clk),
    .rst         (rst),
    .req_i       (req),
    .l2r_done_i  (l2r_done),
    .r2l_start_i (r2l_start),
    .rd_valid_i  (rd_valid),
    .rd_data_i   (rd_data),
    .rd_pop_o    (rd_pop),
    .out_flit_o  (out_flit_o),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .resp_idle_o (resp_idle)
  );

endmodule

`default_nettype wire

// File: hw/dma_target_pkg.sv
//////////////////////////////////////////////////
// DMA target types
// Flit layout, header view and request descriptor
//////////////////////////////////////////////////

`default_nettype none

`include "dma_target_config.svh"

package dma_target_pkg;

  // Flit type field, top two bits of every flit
  typedef enum logic [1:0] {
    FLIT_PAYLOAD = 2'b00,
    FLIT_HEADER  = 2'b01,
    FLIT_LAST    = 2'b10,
    FLIT_SINGLE  = 2'b11
  } flit_type_e;

  // DMA packet kinds
  typedef enum logic [1:0] {
    PKT_L2R_REQ  = 2'b00,
    PKT_R2L_REQ  = 2'b01,
    PKT_L2R_RESP = 2'b10,
    PKT_R2L_RESP = 2'b11
  } pkt_type_e;

  // Header body, 32 bits, destination in the top bits
  typedef struct packed {
    logic [4:0]                 dest;
    logic [2:0]                 cls;
    logic [4:0]                 src;
    pkt_type_e                  pkt_type;
    logic [3:0]                 pkt_id;
    logic                       last;
    logic [`DMA_SIZE_WIDTH-1:0] size;
  } dma_hdr_t;

  // Same 32 bits seen as header or as plain data/address word
  typedef union packed {
    dma_hdr_t                   hdr;
    logic [`DMA_DATA_WIDTH-1:0] word;
  } dma_flit_body_u;

  typedef struct packed {
    flit_type_e     ftype;
    dma_flit_body_u body;
  } dma_flit_t;

  // Request descriptor, shared by memory access and response side
  typedef struct packed {
    logic [4:0]                 src;
    logic [3:0]                 id;
    logic [`DMA_SIZE_WIDTH-1:0] words;
    logic [`DMA_ADDR_WIDTH-1:0] laddr;
    logic [`DMA_ADDR_WIDTH-1:0] raddr;
  } dma_req_t;

  // Single memory write command
  typedef struct packed {
    logic                       en;
    logic [`DMA_ADDR_WIDTH-1:0] addr;
    logic [`DMA_DATA_WIDTH-1:0] data;
  } mem_wr_t;

endpackage

`default_nettype wire

// File: include/dma_target_config.svh
//////////////////////////////////////////////////
// DMA target build constants
// Flit, address and packet sizes, tile identity
//////////////////////////////////////////////////

`ifndef DMA_TARGET_CONFIG_SVH
`define DMA_TARGET_CONFIG_SVH

// NoC flit: 2-bit flit type on top of a 32-bit body
`define DMA_FLIT_WIDTH 34

// Local memory port
`define DMA_ADDR_WIDTH 32
`define DMA_DATA_WIDTH 32

// Maximum flits in one NoC packet
`define DMA_PACKET_SIZE 16

// Header and address flit take two slots of each response packet
`define DMA_MAX_PAYLOAD (`DMA_PACKET_SIZE - 2)

// Id of the tile that hosts this target
`define DMA_TILE_ID 5'd3

// Word-count field of the header
`define DMA_SIZE_WIDTH 12

// Traffic class used for all DMA packets
`define DMA_PKT_CLASS 3'd2

`endif

// File: run.sh
#!/usr/bin/env bash
# Build and run the DMA target testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module tb_dma_target --Mdir "$BUILD_DIR" -o sim_dma_target -f flist.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

# Keep running after an assertion error so the testbench can report
"$BUILD_DIR/sim_dma_target" +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "=== FAIL ===" "$LOG"; then
  exit 1
fi
exit 0
